// File: list.f
vdp_pkg.sv
vdp_csr.sv
vdp_operand_fetch.sv
vdp_dot_unit.sv
vdp_top.sv
tb_vdp_mem.sv
tb_vdp_checker.sv
tb_vdp.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_vdp -o sim_vdp

output=$(./obj_dir/sim_vdp)
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
fi
exit 1

// File: tb_vdp.sv
`timescale 1ns/1ns

module tb_vdp
  import vdp_pkg::*;
();

  localparam int WORD_W     = vdp_word_w_c;
  localparam int ADDR_W     = vdp_addr_w_c;
  localparam int MAX_LEN    = vdp_max_len_c;
  localparam int RD_CREDITS = vdp_rd_credits_c;
  localparam int NUM_TESTS  = 8;

  typedef struct packed {
    logic [127:0] name;
    logic [31:0]  a_ptr;
    logic [31:0]  b_ptr;
    logic [31:0]  len;
    logic [31:0]  res_ptr;
    logic         starve;
  } test_t;

  test_t tests [NUM_TESTS];

  logic              clk_i = 1'b0;
  logic              reset_i = 1'b1;
  logic              csr_v = 1'b0;
  logic              csr_we = 1'b0;
  vdp_csr_idx_e      csr_addr = csr_a_ptr;
  logic [WORD_W-1:0] csr_wdata = '0;
  logic [WORD_W-1:0] csr_rdata;
  logic              csr_rvalid;
  logic              rd_a_v;
  logic [ADDR_W-1:0] rd_a_addr;
  logic              rd_a_resp_v;
  logic [WORD_W-1:0] rd_a_resp_data;
  logic              rd_a_credit;
  logic              rd_b_v;
  logic [ADDR_W-1:0] rd_b_addr;
  logic              rd_b_resp_v;
  logic [WORD_W-1:0] rd_b_resp_data;
  logic              rd_b_credit;
  logic              wr_v;
  logic [ADDR_W-1:0] wr_addr;
  logic [WORD_W-1:0] wr_data;
  logic              wr_credit = 1'b0;
  int                credit_wait = 0;
  int                credits_back = 0;

  // stimulus and expectations handed to the checker
  logic              hold = 1'b0;
  logic [127:0]      test_name = '0;
  logic [ADDR_W-1:0] job_a_ptr = '0;
  logic [ADDR_W-1:0] job_b_ptr = '0;
  logic [ADDR_W-1:0] job_res_ptr = '0;
  logic [31:0]       job_len = '0;
  logic              test_done = 1'b0;
  int                exp_writes = 0;
  logic [WORD_W-1:0] exp_rdata = '0;
  int                pass_cnt;
  int                fail_cnt;

  always #4 clk_i = ~clk_i;

  vdp_top #(
    .WORD_W     (WORD_W),
    .ADDR_W     (ADDR_W),
    .MAX_LEN    (MAX_LEN),
    .RD_CREDITS (RD_CREDITS)
  ) dut0 (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .csr_v_i          (csr_v),
    .csr_we_i         (csr_we),
    .csr_addr_i       (csr_addr),
    .csr_wdata_i      (csr_wdata),
    .csr_rdata_o      (csr_rdata),
    .csr_rvalid_o     (csr_rvalid),
    .rd_a_v_o         (rd_a_v),
    .rd_a_addr_o      (rd_a_addr),
    .rd_a_resp_v_i    (rd_a_resp_v),
    .rd_a_resp_data_i (rd_a_resp_data),
    .rd_a_credit_i    (rd_a_credit),
    .rd_b_v_o         (rd_b_v),
    .rd_b_addr_o      (rd_b_addr),
    .rd_b_resp_v_i    (rd_b_resp_v),
    .rd_b_resp_data_i (rd_b_resp_data),
    .rd_b_credit_i    (rd_b_credit),
    .wr_v_o           (wr_v),
    .wr_addr_o        (wr_addr),
    .wr_data_o        (wr_data),
    .wr_credit_i      (wr_credit)
  );

  tb_vdp_mem #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_mem_a (
    .clk_i       (clk_i),
    .hold_i      (hold),
    .rd_v_i      (rd_a_v),
    .rd_addr_i   (rd_a_addr),
    .resp_v_o    (rd_a_resp_v),
    .resp_data_o (rd_a_resp_data),
    .credit_o    (rd_a_credit)
  );

  tb_vdp_mem #(.WORD_W(WORD_W), .ADDR_W(ADDR_W)) u_mem_b (
    .clk_i       (clk_i),
    .hold_i      (hold),
    .rd_v_i      (rd_b_v),
    .rd_addr_i   (rd_b_addr),
    .resp_v_o    (rd_b_resp_v),
    .resp_data_o (rd_b_resp_data),
    .credit_o    (rd_b_credit)
  );

  tb_vdp_checker #(.WORD_W(WORD_W), .ADDR_W(ADDR_W), .RD_CREDITS(RD_CREDITS)) u_check (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .test_name_i   (test_name),
    .a_ptr_i       (job_a_ptr),
    .b_ptr_i       (job_b_ptr),
    .res_ptr_i     (job_res_ptr),
    .len_i         (job_len),
    .test_done_i   (test_done),
    .exp_writes_i  (exp_writes),
    .exp_rdata_i   (exp_rdata),
    .csr_v_i       (csr_v),
    .csr_we_i      (csr_we),
    .csr_rvalid_i  (csr_rvalid),
    .csr_rdata_i   (csr_rdata),
    .wr_v_i        (wr_v),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .rd_a_v_i      (rd_a_v),
    .rd_a_addr_i   (rd_a_addr),
    .rd_a_credit_i (rd_a_credit),
    .rd_b_v_i      (rd_b_v),
    .rd_b_addr_i   (rd_b_addr),
    .rd_b_credit_i (rd_b_credit),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  // write credit goes back two cycles after the write is seen
  always @(negedge clk_i) begin
    wr_credit <= 1'b0;
    if (credit_wait == 1) begin
      wr_credit    <= 1'b1;
      credits_back <= credits_back + 1;
    end
    if (credit_wait > 0) begin
      credit_wait <= credit_wait - 1;
    end
    if (wr_v) begin
      credit_wait <= 2;
    end
  end

  task automatic csr_write(input vdp_csr_idx_e addr, input logic [WORD_W-1:0] data);
    csr_v     = 1'b1;
    csr_we    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk_i);
    csr_v  = 1'b0;
    csr_we = 1'b0;
  endtask

  // expected value stays put until the read data has come back
  task automatic csr_read(input vdp_csr_idx_e addr, input logic [WORD_W-1:0] expected);
    exp_rdata = expected;
    csr_v     = 1'b1;
    csr_we    = 1'b0;
    csr_addr  = addr;
    @(negedge clk_i);
    csr_v = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    @(negedge clk_i);
    test_done = 1'b0;
  endtask

  task automatic run_job(input test_t tc);
    int target;
    test_name   = tc.name;
    job_a_ptr   = tc.a_ptr;
    job_b_ptr   = tc.b_ptr;
    job_res_ptr = tc.res_ptr;
    job_len     = tc.len;
    exp_writes  = 1;
    // junk in the upper half must not reach the pointers
    csr_write(csr_a_ptr, {32'hffff_ffff, tc.a_ptr});
    csr_write(csr_b_ptr, {32'hffff_ffff, tc.b_ptr});
    csr_write(csr_len, WORD_W'(tc.len));
    csr_write(csr_res_ptr, {32'hffff_ffff, tc.res_ptr});
    csr_read(csr_a_ptr, WORD_W'(tc.a_ptr));
    csr_read(csr_b_ptr, WORD_W'(tc.b_ptr));
    csr_read(csr_len, WORD_W'(tc.len));
    csr_read(csr_res_ptr, WORD_W'(tc.res_ptr));
    target = credits_back + 1;
    hold = tc.starve;
    csr_write(csr_start, WORD_W'(1));
    csr_read(csr_status, WORD_W'(0));
    if (tc.starve) begin
      repeat (17) @(negedge clk_i);
      hold = 1'b0;
    end
    while (!wr_v) begin
      @(negedge clk_i);
    end
    // a start while the result write is in flight must not launch a second job
    csr_write(csr_start, WORD_W'(1));
    while (credits_back < target) begin
      @(negedge clk_i);
    end
    @(negedge clk_i);
    csr_read(csr_status, WORD_W'(1));
    repeat (12) @(negedge clk_i);
    finish_test();
  endtask

  initial begin
    void'($urandom(51975));
    tests[0] = '{"full_len", 32'h0000_0100, 32'h0000_0800, 32'd8, 32'h0000_2000, 1'b0};
    tests[1] = '{"len_one", 32'h0000_0040, 32'h0000_0048, 32'd1, 32'h0000_2008, 1'b0};
    tests[2] = '{"len_three", 32'h0000_1000, 32'h0000_3000, 32'd3, 32'h0000_2010, 1'b0};
    tests[3] = '{"len_zero", 32'h0000_0200, 32'h0000_0300, 32'd0, 32'h0000_2018, 1'b0};
    tests[4] = '{"starve_full", 32'h0000_4000, 32'h0000_5008, 32'd8, 32'h0000_2020, 1'b1};
    tests[5] = '{"starve_short", 32'h0000_0088, 32'h0000_0090, 32'd3, 32'h0000_2028, 1'b1};
    tests[6] = '{"back_to_back", 32'h0000_7ff8, 32'h0000_0010, 32'd5, 32'h0000_2030, 1'b0};
    tests[7] = '{"wrap_big", 32'hffff_ff00, 32'hf000_0000, 32'd8, 32'h0000_2038, 1'b0};
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    test_name  = "after_reset";
    exp_writes = 0;
    csr_read(csr_status, WORD_W'(1));
    csr_read(vdp_csr_idx_e'(3'd7), '0);
    finish_test();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_job(tests[t]);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == NUM_TESTS + 1) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat ((NUM_TESTS + 1) * 200) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, a job never completed",
             (NUM_TESTS + 1) * 200);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: tb_vdp_checker.sv
`timescale 1ns/1ns

module tb_vdp_checker
  import vdp_pkg::*;
#(
  parameter int WORD_W     = vdp_word_w_c,
  parameter int ADDR_W     = vdp_addr_w_c,
  parameter int RD_CREDITS = vdp_rd_credits_c
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic [127:0]      test_name_i,
  input  logic [ADDR_W-1:0] a_ptr_i,
  input  logic [ADDR_W-1:0] b_ptr_i,
  input  logic [ADDR_W-1:0] res_ptr_i,
  input  logic [31:0]       len_i,
  input  logic              test_done_i,
  input  int                exp_writes_i,
  input  logic [WORD_W-1:0] exp_rdata_i,
  input  logic              csr_v_i,
  input  logic              csr_we_i,
  input  logic              csr_rvalid_i,
  input  logic [WORD_W-1:0] csr_rdata_i,
  input  logic              wr_v_i,
  input  logic [ADDR_W-1:0] wr_addr_i,
  input  logic [WORD_W-1:0] wr_data_i,
  input  logic              rd_a_v_i,
  input  logic [ADDR_W-1:0] rd_a_addr_i,
  input  logic              rd_a_credit_i,
  input  logic              rd_b_v_i,
  input  logic [ADDR_W-1:0] rd_b_addr_i,
  input  logic              rd_b_credit_i,
  output int                pass_cnt_o,
  output int                fail_cnt_o
);

  localparam int BYTES = WORD_W / 8;

  int   errors = 0;
  int   writes = 0;
  int   out_a = 0;
  int   out_b = 0;
  int   idx_a = 0;
  int   idx_b = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  logic rd_req_q = 1'b0;

  function automatic logic [WORD_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return WORD_W'(addr) * WORD_W'(3) + WORD_W'(1);
  endfunction

  // byte address of word idx of a vector
  function automatic logic [ADDR_W-1:0] word_addr(input logic [ADDR_W-1:0] base,
                                                  input int idx);
    return base + ADDR_W'(idx * BYTES);
  endfunction

  // reference dot product, wraps modulo 2^WORD_W
  function automatic logic [WORD_W-1:0] dot_expected();
    logic [WORD_W-1:0] acc;
    logic [ADDR_W-1:0] off;
    acc = '0;
    for (int i = 0; i < int'(len_i); i++) begin
      off = ADDR_W'(i * BYTES);
      acc = acc + mem_word(a_ptr_i + off) * mem_word(b_ptr_i + off);
    end
    return acc;
  endfunction

  task automatic report_mismatch(input string what, input logic [WORD_W-1:0] exp_val,
                                 input logic [WORD_W-1:0] act_val);
    $display("[FAIL] %0s %0s expected 0x%0h actual 0x%0h", test_name_i, what, exp_val,
             act_val);
    errors = errors + 1;
  endtask

  always @(posedge clk_i) begin
    // outstanding reads per lane, counted at the ports
    out_a = out_a + (rd_a_v_i ? 1 : 0) - (rd_a_credit_i ? 1 : 0);
    out_b = out_b + (rd_b_v_i ? 1 : 0) - (rd_b_credit_i ? 1 : 0);
    if (out_a > RD_CREDITS || out_b > RD_CREDITS) begin
      $display("%0s: a lane has more reads in flight than it has credits (a %0d, b %0d)",
               test_name_i, out_a, out_b);
      errors = errors + 1;
    end
    // each lane walks its vector one word at a time from the base
    if (rd_a_v_i) begin
      if (rd_a_addr_i !== word_addr(a_ptr_i, idx_a)) begin
        report_mismatch("lane a address", WORD_W'(word_addr(a_ptr_i, idx_a)),
                        WORD_W'(rd_a_addr_i));
      end
      idx_a = idx_a + 1;
    end
    if (rd_b_v_i) begin
      if (rd_b_addr_i !== word_addr(b_ptr_i, idx_b)) begin
        report_mismatch("lane b address", WORD_W'(word_addr(b_ptr_i, idx_b)),
                        WORD_W'(rd_b_addr_i));
      end
      idx_b = idx_b + 1;
    end
    if (wr_v_i) begin
      writes = writes + 1;
      if (wr_addr_i !== res_ptr_i) begin
        report_mismatch("write address", WORD_W'(res_ptr_i), WORD_W'(wr_addr_i));
      end
      if (wr_data_i !== dot_expected()) begin
        report_mismatch("write data", dot_expected(), wr_data_i);
      end
    end
    // read data is due exactly one cycle after the request
    if (!reset_i && csr_rvalid_i !== rd_req_q) begin
      report_mismatch("read valid", WORD_W'(rd_req_q), WORD_W'(csr_rvalid_i));
    end
    rd_req_q = !reset_i && csr_v_i && !csr_we_i;
    if (csr_rvalid_i && csr_rdata_i !== exp_rdata_i) begin
      report_mismatch("register read", exp_rdata_i, csr_rdata_i);
    end
    if (test_done_i) begin
      if (writes != exp_writes_i) begin
        report_mismatch("write count", WORD_W'(exp_writes_i), WORD_W'(writes));
      end
      if (idx_a != int'(len_i)) begin
        report_mismatch("lane a reads", WORD_W'(len_i), WORD_W'(idx_a));
      end
      if (idx_b != int'(len_i)) begin
        report_mismatch("lane b reads", WORD_W'(len_i), WORD_W'(idx_b));
      end
      if (errors == 0) begin
        pass_cnt = pass_cnt + 1;
        $display("test %0s ok", test_name_i);
      end else begin
        fail_cnt = fail_cnt + 1;
        $display("test %0s failed with %0d errors", test_name_i, errors);
      end
      errors = 0;
      writes = 0;
      idx_a  = 0;
      idx_b  = 0;
    end
  end

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

endmodule

// File: tb_vdp_mem.sv
`timescale 1ns/1ns

module tb_vdp_mem
  import vdp_pkg::*;
#(
  parameter int WORD_W = vdp_word_w_c,
  parameter int ADDR_W = vdp_addr_w_c
) (
  input  logic              clk_i,
  input  logic              hold_i,
  input  logic              rd_v_i,
  input  logic [ADDR_W-1:0] rd_addr_i,
  output logic              resp_v_o,
  output logic [WORD_W-1:0] resp_data_o,
  output logic              credit_o
);

  logic [ADDR_W-1:0] addr_q [$];
  int                due_q [$];
  int                cycle = 0;
  int                last_due = 0;
  logic              resp_v_r = 1'b0;
  logic [WORD_W-1:0] resp_data_r = '0;
  logic              credit_r = 1'b0;

  // memory contents follow the address, word at x holds 3x+1
  function automatic logic [WORD_W-1:0] word_at(input logic [ADDR_W-1:0] addr);
    return WORD_W'(addr) * WORD_W'(3) + WORD_W'(1);
  endfunction

  // requests are taken and answers driven on the falling edge
  always @(negedge clk_i) begin : serve
    int due;
    cycle = cycle + 1;
    resp_v_r <= 1'b0;
    credit_r <= 1'b0;
    if (rd_v_i) begin
      due = cycle + int'($urandom_range(1, 4));
      // keep answers in order, one per cycle
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      addr_q.push_back(rd_addr_i);
      due_q.push_back(due);
    end
    // while held, neither answers nor credits go back
    if (!hold_i && addr_q.size() > 0 && due_q[0] <= cycle) begin
      resp_v_r    <= 1'b1;
      resp_data_r <= word_at(addr_q.pop_front());
      credit_r    <= 1'b1;
      void'(due_q.pop_front());
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = resp_data_r;
  assign credit_o    = credit_r;

endmodule

// File: vdp_top.sv
`timescale 1ns/1ns

module vdp_top
  import vdp_pkg::*;
#(
  parameter int WORD_W     = vdp_word_w_c,
  parameter int ADDR_W     = vdp_addr_w_c,
  parameter int MAX_LEN    = vdp_max_len_c,
  parameter int RD_CREDITS = vdp_rd_credits_c
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              csr_v_i,
  input  logic              csr_we_i,
  input  vdp_csr_idx_e      csr_addr_i,
  input  logic [WORD_W-1:0] csr_wdata_i,
  output logic [WORD_W-1:0] csr_rdata_o,
  output logic              csr_rvalid_o,
  output logic              rd_a_v_o,
  output logic [ADDR_W-1:0] rd_a_addr_o,
  input  logic              rd_a_resp_v_i,
  input  logic [WORD_W-1:0] rd_a_resp_data_i,
  input  logic              rd_a_credit_i,
  output logic              rd_b_v_o,
  output logic [ADDR_W-1:0] rd_b_addr_o,
  input  logic              rd_b_resp_v_i,
  input  logic [WORD_W-1:0] rd_b_resp_data_i,
  input  logic              rd_b_credit_i,
  output logic              wr_v_o,
  output logic [ADDR_W-1:0] wr_addr_o,
  output logic [WORD_W-1:0] wr_data_o,
  input  logic              wr_credit_i
);

  localparam int LEN_W = $clog2(MAX_LEN) + 1;

  logic                      start;
  logic                      done;
  logic [ADDR_W-1:0]         a_ptr;
  logic [ADDR_W-1:0]         b_ptr;
  logic [ADDR_W-1:0]         res_ptr;
  logic [LEN_W-1:0]          len;
  logic                      a_full;
  logic                      b_full;
  logic [MAX_LEN*WORD_W-1:0] vec_a;
  logic [MAX_LEN*WORD_W-1:0] vec_b;

  vdp_csr #(
    .WORD_W  (WORD_W),
    .ADDR_W  (ADDR_W),
    .MAX_LEN (MAX_LEN)
  ) u_csr (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_v_i      (csr_v_i),
    .csr_we_i     (csr_we_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .done_i       (done),
    .csr_rdata_o  (csr_rdata_o),
    .csr_rvalid_o (csr_rvalid_o),
    .start_o      (start),
    .a_ptr_o      (a_ptr),
    .b_ptr_o      (b_ptr),
    .res_ptr_o    (res_ptr),
    .len_o        (len)
  );

  // both lanes see the same start and length
  vdp_operand_fetch #(
    .WORD_W     (WORD_W),
    .ADDR_W     (ADDR_W),
    .MAX_LEN    (MAX_LEN),
    .RD_CREDITS (RD_CREDITS)
  ) u_fetch_a (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .start_i        (start),
    .base_i         (a_ptr),
    .len_i          (len),
    .rd_resp_v_i    (rd_a_resp_v_i),
    .rd_resp_data_i (rd_a_resp_data_i),
    .rd_credit_i    (rd_a_credit_i),
    .rd_v_o         (rd_a_v_o),
    .rd_addr_o      (rd_a_addr_o),
    .full_o         (a_full),
    .vec_o          (vec_a)
  );

  vdp_operand_fetch #(
    .WORD_W     (WORD_W),
    .ADDR_W     (ADDR_W),
    .MAX_LEN    (MAX_LEN),
    .RD_CREDITS (RD_CREDITS)
  ) u_fetch_b (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .start_i        (start),
    .base_i         (b_ptr),
    .len_i          (len),
    .rd_resp_v_i    (rd_b_resp_v_i),
    .rd_resp_data_i (rd_b_resp_data_i),
    .rd_credit_i    (rd_b_credit_i),
    .rd_v_o         (rd_b_v_o),
    .rd_addr_o      (rd_b_addr_o),
    .full_o         (b_full),
    .vec_o          (vec_b)
  );

  vdp_dot_unit #(
    .WORD_W  (WORD_W),
    .ADDR_W  (ADDR_W),
    .MAX_LEN (MAX_LEN)
  ) u_dot (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (start),
    .a_full_i    (a_full),
    .b_full_i    (b_full),
    .vec_a_i     (vec_a),
    .vec_b_i     (vec_b),
    .res_ptr_i   (res_ptr),
    .wr_credit_i (wr_credit_i),
    .wr_v_o      (wr_v_o),
    .wr_addr_o   (wr_addr_o),
    .wr_data_o   (wr_data_o),
    .done_o      (done)
  );

endmodule

// File: vdp_dot_unit.sv
`timescale 1ns/1ns

module vdp_dot_unit
  import vdp_pkg::*;
#(
  parameter int WORD_W  = vdp_word_w_c,
  parameter int ADDR_W  = vdp_addr_w_c,
  parameter int MAX_LEN = vdp_max_len_c
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic                      a_full_i,
  input  logic                      b_full_i,
  input  logic [MAX_LEN*WORD_W-1:0] vec_a_i,
  input  logic [MAX_LEN*WORD_W-1:0] vec_b_i,
  input  logic [ADDR_W-1:0]         res_ptr_i,
  input  logic                      wr_credit_i,
  output logic                      wr_v_o,
  output logic [ADDR_W-1:0]         wr_addr_o,
  output logic [WORD_W-1:0]         wr_data_o,
  output logic                      done_o
);

  // adder tree is padded up to a power of two
  localparam int LEAVES = 1 << $clog2(MAX_LEN);

  logic              armed_r;
  logic              prod_v_r;
  logic              sum_v_r;
  logic              credit_r;
  logic              written_r;
  logic              both_full;
  logic [WORD_W-1:0] prod_r [MAX_LEN];
  logic [WORD_W-1:0] sum_r;
  logic [WORD_W-1:0] sum_next;
  logic [ADDR_W-1:0] res_ptr_r;

  assign both_full = armed_r & a_full_i & b_full_i;

  // products keep the low word only
  always_ff @(posedge clk_i) begin
    if (both_full) begin
      for (int i = 0; i < MAX_LEN; i++) begin
        prod_r[i] <= vec_a_i[i*WORD_W +: WORD_W] * vec_b_i[i*WORD_W +: WORD_W];
      end
    end
  end

  always_comb begin
    logic [WORD_W-1:0] node [2*LEAVES-1];
    for (int i = 0; i < LEAVES; i++) begin
      if (i < MAX_LEN) begin
        node[LEAVES-1+i] = prod_r[i];
      end else begin
        node[LEAVES-1+i] = '0;
      end
    end
    // node n sums its children 2n+1 and 2n+2
    for (int n = LEAVES - 2; n >= 0; n--) begin
      node[n] = node[2*n+1] + node[2*n+2];
    end
    sum_next = node[0];
  end

  always_ff @(posedge clk_i) begin
    if (prod_v_r) begin
      sum_r <= sum_next;
    end
    if (start_i) begin
      res_ptr_r <= res_ptr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      armed_r   <= 1'b0;
      prod_v_r  <= 1'b0;
      sum_v_r   <= 1'b0;
      credit_r  <= 1'b1;
      written_r <= 1'b0;
    end else begin
      if (start_i) begin
        armed_r <= 1'b1;
      end else if (both_full) begin
        armed_r <= 1'b0;
      end
      prod_v_r <= both_full;
      if (prod_v_r) begin
        sum_v_r <= 1'b1;
      end else if (wr_v_o) begin
        sum_v_r <= 1'b0;
      end
      // single write credit, out from the write until memory returns it
      if (wr_v_o) begin
        credit_r <= 1'b0;
      end else if (wr_credit_i) begin
        credit_r <= 1'b1;
      end
      if (start_i) begin
        written_r <= 1'b0;
      end else if (wr_v_o) begin
        written_r <= 1'b1;
      end
    end
  end

  assign wr_v_o    = sum_v_r & credit_r;
  assign wr_addr_o = res_ptr_r;
  assign wr_data_o = sum_r;
  assign done_o    = ~credit_r & wr_credit_i;

  a_one_write_per_job: assert property (@(posedge clk_i) disable iff (reset_i)
    wr_v_o |-> !written_r);

endmodule

// File: vdp_operand_fetch.sv
`timescale 1ns/1ns

module vdp_operand_fetch
  import vdp_pkg::*;
#(
  parameter int  WORD_W     = vdp_word_w_c,
  parameter int  ADDR_W     = vdp_addr_w_c,
  parameter int  MAX_LEN    = vdp_max_len_c,
  parameter int  RD_CREDITS = vdp_rd_credits_c,
  localparam int LEN_W      = $clog2(MAX_LEN) + 1
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      start_i,
  input  logic [ADDR_W-1:0]         base_i,
  input  logic [LEN_W-1:0]          len_i,
  input  logic                      rd_resp_v_i,
  input  logic [WORD_W-1:0]         rd_resp_data_i,
  input  logic                      rd_credit_i,
  output logic                      rd_v_o,
  output logic [ADDR_W-1:0]         rd_addr_o,
  output logic                      full_o,
  output logic [MAX_LEN*WORD_W-1:0] vec_o
);

  localparam int IDX_W  = (MAX_LEN > 1) ? $clog2(MAX_LEN) : 1;
  localparam int CRED_W = $clog2(RD_CREDITS + 1);
  localparam int BYTES  = WORD_W / 8;

  logic [ADDR_W-1:0] base_r;
  logic [LEN_W-1:0]  len_r;
  logic [LEN_W-1:0]  len_clamp;
  logic [LEN_W-1:0]  issue_cnt_r;
  logic [LEN_W-1:0]  recv_cnt_r;
  logic [CRED_W-1:0] credit_cnt_r;
  logic              loaded_r;
  logic [WORD_W-1:0] buf_r [MAX_LEN];

  // lengths past the buffer size are cut to the buffer size
  assign len_clamp = (len_i > LEN_W'(MAX_LEN)) ? LEN_W'(MAX_LEN) : len_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      loaded_r    <= 1'b0;
      len_r       <= '0;
      issue_cnt_r <= '0;
      recv_cnt_r  <= '0;
    end else if (start_i) begin
      loaded_r    <= 1'b1;
      len_r       <= len_clamp;
      issue_cnt_r <= '0;
      recv_cnt_r  <= '0;
    end else begin
      if (rd_v_o) begin
        issue_cnt_r <= issue_cnt_r + 1'b1;
      end
      if (rd_resp_v_i) begin
        recv_cnt_r <= recv_cnt_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      base_r <= base_i;
    end
  end

  // one credit spent per request, one back per credit pulse
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credit_cnt_r <= CRED_W'(RD_CREDITS);
    end else begin
      credit_cnt_r <= credit_cnt_r + CRED_W'(rd_credit_i) - CRED_W'(rd_v_o);
    end
  end

  // zeroed words past len keep the dot product unaffected
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      for (int i = 0; i < MAX_LEN; i++) begin
        buf_r[i] <= '0;
      end
    end else if (rd_resp_v_i) begin
      buf_r[recv_cnt_r[IDX_W-1:0]] <= rd_resp_data_i;
    end
  end

  assign rd_v_o    = loaded_r && (issue_cnt_r < len_r) && (credit_cnt_r != '0);
  assign rd_addr_o = base_r + ADDR_W'(issue_cnt_r) * ADDR_W'(BYTES);
  assign full_o    = loaded_r && (recv_cnt_r == len_r);

  for (genvar i = 0; i < MAX_LEN; i++) begin : g_vec
    assign vec_o[i*WORD_W +: WORD_W] = buf_r[i];
  end

  // last credit gone and none returning, so the port must idle next cycle
  a_no_req_without_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    (rd_v_o && (credit_cnt_r == CRED_W'(1)) && !rd_credit_i) |=> !rd_v_o);

  // memory never returns more credits than were spent
  a_credit_bound: assert property (@(posedge clk_i) disable iff (reset_i)
    credit_cnt_r <= CRED_W'(RD_CREDITS));

  a_resp_within_len: assert property (@(posedge clk_i) disable iff (reset_i)
    rd_resp_v_i |-> (loaded_r && (recv_cnt_r < len_r)));

endmodule

// File: vdp_csr.sv
`timescale 1ns/1ns

module vdp_csr
  import vdp_pkg::*;
#(
  parameter int  WORD_W  = vdp_word_w_c,
  parameter int  ADDR_W  = vdp_addr_w_c,
  parameter int  MAX_LEN = vdp_max_len_c,
  localparam int LEN_W   = $clog2(MAX_LEN) + 1
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              csr_v_i,
  input  logic              csr_we_i,
  input  vdp_csr_idx_e      csr_addr_i,
  input  logic [WORD_W-1:0] csr_wdata_i,
  input  logic              done_i,
  output logic [WORD_W-1:0] csr_rdata_o,
  output logic              csr_rvalid_o,
  output logic              start_o,
  output logic [ADDR_W-1:0] a_ptr_o,
  output logic [ADDR_W-1:0] b_ptr_o,
  output logic [ADDR_W-1:0] res_ptr_o,
  output logic [LEN_W-1:0]  len_o
);

  logic [ADDR_W-1:0] a_ptr_r;
  logic [ADDR_W-1:0] b_ptr_r;
  logic [ADDR_W-1:0] res_ptr_r;
  logic [LEN_W-1:0]  len_r;
  logic              busy_r;
  logic              start_r;
  logic [WORD_W-1:0] rdata_r;
  logic              rvalid_r;
  logic              wr_en;
  logic              rd_en;
  logic              start_req;
  logic [WORD_W-1:0] rd_mux;

  assign wr_en     = csr_v_i & csr_we_i;
  assign rd_en     = csr_v_i & ~csr_we_i;
  assign start_req = wr_en & (csr_addr_i == csr_start) & ~busy_r;

  // status and unknown indexes fall through and are not writable
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r   <= '0;
      b_ptr_r   <= '0;
      res_ptr_r <= '0;
      len_r     <= '0;
    end else if (wr_en) begin
      case (csr_addr_i)
        csr_a_ptr:   a_ptr_r   <= csr_wdata_i[ADDR_W-1:0];
        csr_b_ptr:   b_ptr_r   <= csr_wdata_i[ADDR_W-1:0];
        csr_len:     len_r     <= csr_wdata_i[LEN_W-1:0];
        csr_res_ptr: res_ptr_r <= csr_wdata_i[ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // a start while busy is dropped, busy holds until the result write completes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r  <= 1'b0;
      start_r <= 1'b0;
    end else begin
      start_r <= start_req;
      if (start_req) begin
        busy_r <= 1'b1;
      end else if (done_i) begin
        busy_r <= 1'b0;
      end
    end
  end

  always_comb begin
    case (csr_addr_i)
      csr_a_ptr:   rd_mux = WORD_W'(a_ptr_r);
      csr_b_ptr:   rd_mux = WORD_W'(b_ptr_r);
      csr_len:     rd_mux = WORD_W'(len_r);
      csr_res_ptr: rd_mux = WORD_W'(res_ptr_r);
      csr_status:  rd_mux = {{(WORD_W-1){1'b0}}, ~busy_r};
      default:     rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_r <= rd_mux;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else begin
      rvalid_r <= rd_en;
    end
  end

  assign csr_rdata_o  = rdata_r;
  assign csr_rvalid_o = rvalid_r;
  assign start_o      = start_r;
  assign a_ptr_o      = a_ptr_r;
  assign b_ptr_o      = b_ptr_r;
  assign res_ptr_o    = res_ptr_r;
  assign len_o        = len_r;

  // the dot unit only finishes jobs this block started
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    done_i |-> busy_r);

endmodule

// File: vdp_pkg.sv
package vdp_pkg;

  // default datapath sizes, overridable from the top level
  localparam int vdp_word_w_c = 64;
  localparam int vdp_addr_w_c = 32;

  // longest vector the operand buffers can hold, in words
  localparam int vdp_max_len_c = 8;

  // read requests a lane may have in flight
  localparam int vdp_rd_credits_c = 4;

  localparam int vdp_csr_idx_w_c = 3;

  // host visible register map
  typedef enum logic [vdp_csr_idx_w_c-1:0] {
    csr_a_ptr   = 3'd0,
    csr_b_ptr   = 3'd1,
    csr_len     = 3'd2,
    csr_start   = 3'd3,
    csr_status  = 3'd4,
    csr_res_ptr = 3'd5
  } vdp_csr_idx_e;

endpackage
